/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_fpu_cluster
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/fpu_pkg.sv */
package fpu_pkg;

  // single-precision word and field positions
  typedef logic [31:0] fp_word_t;

  localparam int SIGN_BIT = 31;
  localparam int EXP_HI   = 30;
  localparam int EXP_LO   = 23;
  localparam int FRAC_HI  = 22;

  // retire tag carried alongside each operation
  typedef logic [5:0] fp_tag_t;

  // result buses visible to the operand bypass
  localparam int FWD_BUSES = 4;

  typedef logic [1:0] fwd_sel_t;

  typedef fp_word_t [FWD_BUSES-1:0] fwd_bus_t;

  // operations handled by this cluster
  typedef enum logic [3:0] {
    OP_CMP_EQ   = 4'd0,
    OP_CMP_LT   = 4'd1,
    OP_CMP_LE   = 4'd2,
    OP_AND      = 4'd3,
    OP_OR       = 4'd4,
    OP_XOR      = 4'd5,
    OP_ANDN     = 4'd6,
    OP_NEG      = 4'd7,
    OP_ABS      = 4'd8,
    OP_COPYSIGN = 4'd9
  } fp_op_t;

  // control/status register layout
  localparam int CSR_W        = 2;
  localparam int CSR_TRAP_EN  = 0;
  localparam int CSR_INV_FLAG = 1;

  typedef logic [CSR_W-1:0] csr_word_t;

  // op class, compare ops go to the compare unit
  function automatic logic is_compare(input fp_op_t op);
    logic res;
    case (op)
      OP_CMP_EQ,
      OP_CMP_LT,
      OP_CMP_LE: res = 1'b1;
      default:   res = 1'b0;
    endcase
    return res;
  endfunction

endpackage

/* common/fpu_stage_if.sv */
interface fpu_stage_if;

  // issued operation, owned by the issue stage
  logic             valid;
  fpu_pkg::fp_op_t  op;
  fpu_pkg::fp_tag_t tag;
  fpu_pkg::fp_word_t a;
  fpu_pkg::fp_word_t b;

  // result stage can take an item this cycle
  logic advance;

  modport issue (
    output valid, op, tag, a, b,
    input  advance
  );

  modport exec (
    input  valid, op, tag, a, b,
    output advance
  );

endinterface

/* hw/fp_exec/fp_bitwise_unit.sv */
module fp_bitwise_unit (
  input  fpu_pkg::fp_op_t    op,
  input  fpu_pkg::fp_word_t  a,
  input  fpu_pkg::fp_word_t  b,
  output fpu_pkg::fp_word_t  result
);

  localparam int SB = fpu_pkg::SIGN_BIT;

  always_comb begin
    case (op)
      fpu_pkg::OP_AND:  result = a & b;
      fpu_pkg::OP_OR:   result = a | b;
      fpu_pkg::OP_XOR:  result = a ^ b;
      fpu_pkg::OP_ANDN: result = a & ~b;
      // sign ops only touch the top bit of a
      fpu_pkg::OP_NEG:  result = {~a[SB], a[SB-1:0]};
      fpu_pkg::OP_ABS:  result = {1'b0, a[SB-1:0]};
      fpu_pkg::OP_COPYSIGN: begin
        result = {b[SB], a[SB-1:0]};
      end
      default:          result = '0;
    endcase
  end

endmodule

/* hw/fp_exec/fp_compare_unit.sv */
module fp_compare_unit (
  input  fpu_pkg::fp_op_t    op,
  input  fpu_pkg::fp_word_t  a,
  input  fpu_pkg::fp_word_t  b,
  output fpu_pkg::fp_word_t  result,
  output logic               invalid
);

  logic a_nan;
  logic b_nan;
  logic a_snan;
  logic b_snan;
  logic any_nan;
  logic both_zero;
  logic eq;
  logic lt;

  // nan means exponent all ones with a nonzero fraction
  assign a_nan  = (&a[fpu_pkg::EXP_HI:fpu_pkg::EXP_LO]) && (|a[fpu_pkg::FRAC_HI:0]);
  assign b_nan  = (&b[fpu_pkg::EXP_HI:fpu_pkg::EXP_LO]) && (|b[fpu_pkg::FRAC_HI:0]);
  assign a_snan = a_nan && !a[fpu_pkg::FRAC_HI];
  assign b_snan = b_nan && !b[fpu_pkg::FRAC_HI];
  assign any_nan = a_nan || b_nan;

  // +0 and -0 compare equal
  assign both_zero = (a[fpu_pkg::EXP_HI:0] == '0) && (b[fpu_pkg::EXP_HI:0] == '0);

  assign eq = !any_nan && ((a == b) || both_zero);

  // sign-magnitude ordering
  always_comb begin
    if (any_nan || both_zero) begin
      lt = 1'b0;
    end else if (a[fpu_pkg::SIGN_BIT] != b[fpu_pkg::SIGN_BIT]) begin
      lt = a[fpu_pkg::SIGN_BIT];
    end else if (!a[fpu_pkg::SIGN_BIT]) begin
      lt = a[fpu_pkg::EXP_HI:0] < b[fpu_pkg::EXP_HI:0];
    end else begin
      lt = a[fpu_pkg::EXP_HI:0] > b[fpu_pkg::EXP_HI:0];
    end
  end

  always_comb begin
    result  = '0;
    invalid = 1'b0;
    case (op)
      fpu_pkg::OP_CMP_EQ: begin
        result[0] = eq;
        invalid   = a_snan || b_snan;
      end
      fpu_pkg::OP_CMP_LT: begin
        result[0] = lt;
        invalid   = any_nan;
      end
      fpu_pkg::OP_CMP_LE: begin
        result[0] = lt || eq;
        invalid   = any_nan;
      end
      default: ;
    endcase
  end

endmodule

/* hw/fp_exec/fp_result_stage.sv */
module fp_result_stage (
  input  logic                clk,
  input  logic                rst,
  fpu_stage_if.exec           stage,
  output logic                out_valid,
  input  logic                out_ready,
  output fpu_pkg::fp_word_t   out_data,
  output fpu_pkg::fp_tag_t    out_tag,
  output logic                out_trap,
  input  logic                cfg_we,
  input  fpu_pkg::csr_word_t  cfg_wdata,
  output fpu_pkg::csr_word_t  cfg_rdata
);

  fpu_pkg::fp_word_t cmp_result;
  fpu_pkg::fp_word_t bit_result;
  fpu_pkg::fp_word_t sel_result;
  logic              cmp_invalid;
  logic              trap_en;
  logic              xfer;

  fp_compare_unit i_cmp (
    .op      (stage.op),
    .a       (stage.a),
    .b       (stage.b),
    .result  (cmp_result),
    .invalid (cmp_invalid)
  );

  fp_bitwise_unit i_bit (
    .op     (stage.op),
    .a      (stage.a),
    .b      (stage.b),
    .result (bit_result)
  );

  fpcsr_regs i_csr (
    .clk           (clk),
    .rst           (rst),
    .we            (cfg_we),
    .wdata         (cfg_wdata),
    .raise_invalid (xfer && cmp_invalid),
    .trap_en       (trap_en),
    .rdata         (cfg_rdata)
  );

  assign stage.advance = !out_valid || out_ready;
  assign xfer          = stage.valid && stage.advance;

  assign sel_result = fpu_pkg::is_compare(stage.op) ? cmp_result : bit_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_trap  <= 1'b0;
    end else if (stage.advance) begin
      out_valid <= stage.valid;
      out_trap  <= stage.valid && cmp_invalid && trap_en;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      out_data <= sel_result;
      out_tag  <= stage.tag;
    end
  end

endmodule

/* hw/fp_exec/fpcsr_regs.sv */
module fpcsr_regs (
  input  logic                clk,
  input  logic                rst,
  input  logic                we,
  input  fpu_pkg::csr_word_t  wdata,
  input  logic                raise_invalid,
  output logic                trap_en,
  output fpu_pkg::csr_word_t  rdata
);

  logic inv_flag;

  always_ff @(posedge clk) begin
    if (rst) begin
      trap_en  <= 1'b0;
      inv_flag <= 1'b0;
    end else begin
      if (we) begin
        trap_en <= wdata[fpu_pkg::CSR_TRAP_EN];
      end
      // a raise in the same cycle overrides a clearing write
      if (raise_invalid) begin
        inv_flag <= 1'b1;
      end else if (we) begin
        inv_flag <= wdata[fpu_pkg::CSR_INV_FLAG];
      end
    end
  end

  always_comb begin
    rdata                        = '0;
    rdata[fpu_pkg::CSR_TRAP_EN]  = trap_en;
    rdata[fpu_pkg::CSR_INV_FLAG] = inv_flag;
  end

endmodule

/* hw/fp_issue_stage.sv */
module fp_issue_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  output logic               in_ready,
  input  fpu_pkg::fp_op_t    in_op,
  input  fpu_pkg::fp_tag_t   in_tag,
  input  fpu_pkg::fp_word_t  in_a,
  input  fpu_pkg::fp_word_t  in_b,
  input  logic               fwd_now_a,
  input  logic               fwd_old_a,
  input  logic               fwd_now_b,
  input  logic               fwd_old_b,
  input  fpu_pkg::fwd_sel_t  fwd_sel_a,
  input  fpu_pkg::fwd_sel_t  fwd_sel_b,
  input  fpu_pkg::fwd_bus_t  fwd_bus,
  fpu_stage_if.issue         stage
);

  logic              valid_q;
  fpu_pkg::fp_op_t   op_q;
  fpu_pkg::fp_tag_t  tag_q;
  fpu_pkg::fp_word_t a_q;
  fpu_pkg::fp_word_t b_q;
  fpu_pkg::fp_word_t opnd_a;
  fpu_pkg::fp_word_t opnd_b;

  operand_forward i_fwd_a (
    .clk       (clk),
    .reg_value (in_a),
    .fwd_now   (fwd_now_a),
    .fwd_old   (fwd_old_a),
    .fwd_sel   (fwd_sel_a),
    .fwd_bus   (fwd_bus),
    .operand   (opnd_a)
  );

  operand_forward i_fwd_b (
    .clk       (clk),
    .reg_value (in_b),
    .fwd_now   (fwd_now_b),
    .fwd_old   (fwd_old_b),
    .fwd_sel   (fwd_sel_b),
    .fwd_bus   (fwd_bus),
    .operand   (opnd_b)
  );

  // slot frees up when empty or when the item moves on this cycle
  assign in_ready = !valid_q || stage.advance;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  // payload only loads on acceptance, held under stall
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      op_q  <= in_op;
      tag_q <= in_tag;
      a_q   <= opnd_a;
      b_q   <= opnd_b;
    end
  end

  assign stage.valid = valid_q;
  assign stage.op    = op_q;
  assign stage.tag   = tag_q;
  assign stage.a     = a_q;
  assign stage.b     = b_q;

endmodule

/* hw/fpu_cluster.sv */
module fpu_cluster (
  input  logic                clk,
  input  logic                rst,

  // operation input
  input  logic                in_valid,
  output logic                in_ready,
  input  fpu_pkg::fp_op_t     in_op,
  input  fpu_pkg::fp_tag_t    in_tag,
  input  fpu_pkg::fp_word_t   in_a,
  input  fpu_pkg::fp_word_t   in_b,

  // bypass controls
  input  logic                fwd_now_a,
  input  logic                fwd_old_a,
  input  fpu_pkg::fwd_sel_t   fwd_sel_a,
  input  logic                fwd_now_b,
  input  logic                fwd_old_b,
  input  fpu_pkg::fwd_sel_t   fwd_sel_b,
  input  fpu_pkg::fwd_bus_t   fwd_bus,

  // result output
  output logic                out_valid,
  input  logic                out_ready,
  output fpu_pkg::fp_word_t   out_data,
  output fpu_pkg::fp_tag_t    out_tag,
  output logic                out_trap,

  // csr access
  input  logic                cfg_we,
  input  fpu_pkg::csr_word_t  cfg_wdata,
  output fpu_pkg::csr_word_t  cfg_rdata
);

  fpu_stage_if stage_if ();

  fp_issue_stage i_issue (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .in_tag    (in_tag),
    .in_a      (in_a),
    .in_b      (in_b),
    .fwd_now_a (fwd_now_a),
    .fwd_old_a (fwd_old_a),
    .fwd_now_b (fwd_now_b),
    .fwd_old_b (fwd_old_b),
    .fwd_sel_a (fwd_sel_a),
    .fwd_sel_b (fwd_sel_b),
    .fwd_bus   (fwd_bus),
    .stage     (stage_if.issue)
  );

  fp_result_stage i_result (
    .clk       (clk),
    .rst       (rst),
    .stage     (stage_if.exec),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_tag   (out_tag),
    .out_trap  (out_trap),
    .cfg_we    (cfg_we),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata)
  );

endmodule

/* hw/operand_forward.sv */
module operand_forward (
  input  logic               clk,
  input  fpu_pkg::fp_word_t  reg_value,
  input  logic               fwd_now,
  input  logic               fwd_old,
  input  fpu_pkg::fwd_sel_t  fwd_sel,
  input  fpu_pkg::fwd_bus_t  fwd_bus,
  output fpu_pkg::fp_word_t  operand
);

  // one-cycle-old view of every result bus
  fpu_pkg::fwd_bus_t fwd_bus_q;

  // runs every cycle, stalls do not matter here
  always_ff @(posedge clk) begin
    fwd_bus_q <= fwd_bus;
  end

  // current bus beats old bus beats register file
  always_comb begin
    if (fwd_now) begin
      operand = fwd_bus[fwd_sel];
    end else if (fwd_old) begin
      operand = fwd_bus_q[fwd_sel];
    end else begin
      operand = reg_value;
    end
  end

endmodule

/* project.f */
+incdir+common
common/fpu_pkg.sv
common/fpu_stage_if.sv
hw/operand_forward.sv
hw/fp_issue_stage.sv
hw/fp_exec/fp_compare_unit.sv
hw/fp_exec/fp_bitwise_unit.sv
hw/fp_exec/fpcsr_regs.sv
hw/fp_exec/fp_result_stage.sv
hw/fpu_cluster.sv
verification/fpu_cluster_assert.sv
verification/tb_fpu_cluster.sv

/* verification/fpu_cluster_assert.sv */
module fpu_cluster_assert (
  input logic               clk,
  input logic               rst,
  input logic               in_valid,
  input logic               in_ready,
  input fpu_pkg::fp_op_t    in_op,
  input fpu_pkg::fp_tag_t   in_tag,
  input logic               out_valid,
  input logic               out_ready,
  input fpu_pkg::fp_word_t  out_data,
  input fpu_pkg::fp_tag_t   out_tag,
  input logic               out_trap
);

  // compare class followed through both stages
  logic cmp_issue;
  logic cmp_out;

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      cmp_issue <= (in_op == fpu_pkg::OP_CMP_EQ) || (in_op == fpu_pkg::OP_CMP_LT) ||
                   (in_op == fpu_pkg::OP_CMP_LE);
    end
    if (!out_valid || out_ready) begin
      cmp_out <= cmp_issue;
    end
  end

  reset_quiet: assert property (@(posedge clk) rst |=> !out_valid && !out_trap)
    else $error("output active during or right after reset");

  hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_tag) &&
                                $stable(out_trap))
    else $error("output changed while stalled");

  // the accepted item itself shows up, not just some item
  two_cycle_latency: assert property (@(posedge clk) disable iff (rst)
    (in_valid && in_ready && out_ready) ##1 out_ready |=>
      out_valid && out_tag == $past(in_tag, 2))
    else $error("out_valid missing two cycles after acceptance");

  cmp_bit0_only: assert property (@(posedge clk) disable iff (rst)
    out_valid && cmp_out |-> out_data[31:1] == '0)
    else $error("compare result uses bits above bit 0");

endmodule

bind fpu_cluster fpu_cluster_assert i_fpu_cluster_assert (.*);

/* verification/tb_fpu_cluster.sv */
module tb_fpu_cluster;

  logic                clk;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  fpu_pkg::fp_op_t     in_op;
  fpu_pkg::fp_tag_t    in_tag;
  fpu_pkg::fp_word_t   in_a;
  fpu_pkg::fp_word_t   in_b;
  logic                fwd_now_a;
  logic                fwd_old_a;
  fpu_pkg::fwd_sel_t   fwd_sel_a;
  logic                fwd_now_b;
  logic                fwd_old_b;
  fpu_pkg::fwd_sel_t   fwd_sel_b;
  fpu_pkg::fwd_bus_t   fwd_bus;
  logic                out_valid;
  logic                out_ready;
  fpu_pkg::fp_word_t   out_data;
  fpu_pkg::fp_tag_t    out_tag;
  logic                out_trap;
  logic                cfg_we;
  fpu_pkg::csr_word_t  cfg_wdata;
  fpu_pkg::csr_word_t  cfg_rdata;

  logic [31:0] lfsr_state = 32'h0b1aec72;
  logic [38:0] exp_q[$];
  int          accept_cyc_q[$];
  int          cycle = 0;
  int          mismatch_count = 0;
  int          timeout_count = 0;
  string       test_name = "reset";
  logic        random_ready = 1'b0;
  logic        random_fwd = 1'b0;
  logic        check_latency = 1'b0;
  logic        model_trap_en = 1'b0;
  fpu_pkg::fwd_bus_t old_bus;
  fpu_pkg::fp_tag_t  next_tag = '0;

  fpu_cluster i_fpu_cluster (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // one new bit per lfsr step, taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic is_nan(input logic [31:0] v);
    return (v[30:23] == 8'hff) && (v[22:0] != 0);
  endfunction

  // signed ordering key, both zeros map to 0
  function automatic longint order_key(input logic [31:0] v);
    longint mag;
    mag = longint'(v[30:0]);
    return v[31] ? -mag : mag;
  endfunction

  function automatic logic expected_invalid(input fpu_pkg::fp_op_t op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic snan;
    snan = (is_nan(a) && !a[22]) || (is_nan(b) && !b[22]);
    if (op == fpu_pkg::OP_CMP_EQ) return snan;
    if (op == fpu_pkg::OP_CMP_LT || op == fpu_pkg::OP_CMP_LE) return is_nan(a) || is_nan(b);
    return 1'b0;
  endfunction

  function automatic logic [31:0] expected_result(input fpu_pkg::fp_op_t op,
                                                  input logic [31:0] a, input logic [31:0] b);
    logic nan;
    nan = is_nan(a) || is_nan(b);
    case (op)
      fpu_pkg::OP_CMP_EQ:   return {31'd0, !nan && order_key(a) == order_key(b)};
      fpu_pkg::OP_CMP_LT:   return {31'd0, !nan && order_key(a) < order_key(b)};
      fpu_pkg::OP_CMP_LE:   return {31'd0, !nan && order_key(a) <= order_key(b)};
      fpu_pkg::OP_AND:      return a & b;
      fpu_pkg::OP_OR:       return a | b;
      fpu_pkg::OP_XOR:      return a ^ b;
      fpu_pkg::OP_ANDN:     return a & ~b;
      fpu_pkg::OP_NEG:      return a ^ 32'h8000_0000;
      fpu_pkg::OP_ABS:      return a & 32'h7fff_ffff;
      fpu_pkg::OP_COPYSIGN: return (a & 32'h7fff_ffff) | (b & 32'h8000_0000);
      default:              return '0;
    endcase
  endfunction

  // reference model and scoreboard, read pre-edge values
  always @(posedge clk) begin
    fpu_pkg::fp_word_t ra;
    fpu_pkg::fp_word_t rb;
    logic              inv;
    logic [38:0]       exp_item;
    int                acc;
    cycle++;
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("output handshake with no item pending in test %s", test_name);
        mismatch_count++;
      end else begin
        exp_item = exp_q.pop_front();
        acc = accept_cyc_q.pop_front();
        if ({out_trap, out_tag, out_data} !== exp_item) begin
          $display("ERROR %s expected %h actual %h", test_name, exp_item,
                   {out_trap, out_tag, out_data});
          mismatch_count++;
        end
        if (check_latency && cycle - acc != 2) begin
          $display("ERROR %s latency expected %0d actual %0d", test_name, 2, cycle - acc);
          mismatch_count++;
        end
      end
    end
    // trap enable seen by items issued from this edge on
    if (!rst && cfg_we) begin
      model_trap_en = cfg_wdata[0];
    end
    if (!rst && in_valid && in_ready) begin
      ra = fwd_now_a ? fwd_bus[fwd_sel_a] : fwd_old_a ? old_bus[fwd_sel_a] : in_a;
      rb = fwd_now_b ? fwd_bus[fwd_sel_b] : fwd_old_b ? old_bus[fwd_sel_b] : in_b;
      inv = expected_invalid(in_op, ra, rb);
      exp_q.push_back({inv && model_trap_en, in_tag, expected_result(in_op, ra, rb)});
      accept_cyc_q.push_back(cycle);
    end
    old_bus = fwd_bus;
  end

  task automatic abort_run(input string why);
    timeout_count++;
    $display("%s in test %s", why, test_name);
    $display("errors: mismatches %0d timeouts %0d", mismatch_count, timeout_count);
    $display("STATUS: FAIL");
    $finish;
  endtask

  // per-cycle background drive, always at the falling edge
  task automatic drive_background();
    logic [31:0] r;
    for (int i = 0; i < fpu_pkg::FWD_BUSES; i++) begin
      fwd_bus[i] = take_bits(32);
    end
    if (random_ready) begin
      r = take_bits(1);
      out_ready = r[0];
    end
  endtask

  task automatic send(input fpu_pkg::fp_op_t op, input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    int          waited;
    @(negedge clk);
    drive_background();
    in_valid = 1'b1;
    in_op = op;
    in_tag = next_tag;
    next_tag++;
    in_a = a;
    in_b = b;
    {fwd_now_a, fwd_old_a, fwd_now_b, fwd_old_b, fwd_sel_a, fwd_sel_b} = '0;
    if (random_fwd) begin
      r = take_bits(8);
      {fwd_now_a, fwd_old_a, fwd_now_b, fwd_old_b, fwd_sel_a, fwd_sel_b} = r[7:0];
    end
    waited = 0;
    @(posedge clk);
    while (!in_ready) begin
      if (++waited > 200) begin
        $display("in_ready never came back in test %s", test_name);
        timeout_count++;
        break;
      end
      @(negedge clk);
      drive_background();
      @(posedge clk);
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    in_valid = 1'b0;
    random_ready = 1'b0;
    out_ready = 1'b1;
    while (exp_q.size() != 0) begin
      if (++waited > 200) begin
        $display("results still pending after drain timeout in test %s", test_name);
        timeout_count++;
        break;
      end
      @(negedge clk);
      drive_background();
    end
  endtask

  task automatic csr_write(input logic [1:0] data);
    @(negedge clk);
    cfg_we = 1'b1;
    cfg_wdata = data;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic check_csr(input logic [1:0] expected);
    @(negedge clk);
    if (cfg_rdata !== expected) begin
      $display("ERROR %s expected %h actual %h", test_name, expected, cfg_rdata);
      mismatch_count++;
    end
  endtask

  initial begin
    repeat (200000) @(posedge clk);
    abort_run("simulation ran past its cycle limit");
  end

  initial begin
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] ro;
    logic [31:0] vals[8];
    vals = '{32'h0, 32'h8000_0000, 32'h3f80_0000, 32'h4000_0000,
             32'hbf80_0000, 32'hc000_0000, 32'h7fc0_0000, 32'h7f80_0001};
    rst = 1'b1;
    {in_valid, in_tag, in_a, in_b, fwd_bus, cfg_we, cfg_wdata} = '0;
    {fwd_now_a, fwd_old_a, fwd_sel_a, fwd_now_b, fwd_old_b, fwd_sel_b} = '0;
    in_op = fpu_pkg::OP_AND;
    out_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (out_valid !== 1'b0 || out_trap !== 1'b0 || in_ready !== 1'b1) begin
      $display("ERROR %s expected %h actual %h", test_name, 3'b001,
               {out_valid, out_trap, in_ready});
      mismatch_count++;
    end
    check_csr(2'b00);

    test_name = "bitwise";
    check_latency = 1'b1;
    for (int op = 3; op <= 9; op++) begin
      for (int k = 0; k < 6; k++) begin
        ra = take_bits(32);
        rb = take_bits(32);
        send(fpu_pkg::fp_op_t'(op), ra, rb);
      end
    end
    drain();

    test_name = "compare";
    foreach (vals[i]) begin
      foreach (vals[j]) begin
        for (int op = 0; op <= 2; op++) send(fpu_pkg::fp_op_t'(op), vals[i], vals[j]);
      end
    end
    drain();

    test_name = "trap";
    csr_write(2'b01);
    send(fpu_pkg::OP_CMP_LT, 32'h7fc0_0000, 32'h3f80_0000);
    drain();
    check_csr(2'b11);
    csr_write(2'b01);
    check_csr(2'b01);
    csr_write(2'b00);
    send(fpu_pkg::OP_CMP_EQ, 32'h0, 32'h7f80_0001);
    drain();
    check_csr(2'b10);
    csr_write(2'b00);
    check_csr(2'b00);

    test_name = "bypass";
    random_fwd = 1'b1;
    for (int k = 0; k < 40; k++) begin
      ro = take_bits(4);
      ra = take_bits(32);
      rb = take_bits(32);
      send(fpu_pkg::fp_op_t'(ro % 10), ra, rb);
    end
    drain();

    test_name = "backpressure";
    check_latency = 1'b0;
    random_ready = 1'b1;
    for (int k = 0; k < 60; k++) begin
      ro = take_bits(4);
      ra = take_bits(32);
      rb = take_bits(32);
      send(fpu_pkg::fp_op_t'(ro % 10), ra, rb);
    end
    drain();
    repeat (3) @(posedge clk);

    $display("errors: mismatches %0d timeouts %0d", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
